//--- button_sync.sv
module button_sync
(
	input logic CLK,
	input logic reset,
	input clock_pkg::btn_t btn_raw,
	output clock_pkg::btn_t btn_pulse
);

	// two flop synchronizer stages
	clock_pkg::btn_t sync_1;
	clock_pkg::btn_t sync_2;
	// last synchronized level, for edge detect
	clock_pkg::btn_t sync_prev;

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			sync_1 <= '0;
			sync_2 <= '0;
			sync_prev <= '0;
			btn_pulse <= '0;
		end
		else
		begin
			sync_1 <= btn_raw;
			sync_2 <= sync_1;
			sync_prev <= sync_2;
			// rising edge only, a held button gives one pulse
			btn_pulse <= sync_2 & ~sync_prev;
		end
	end

endmodule

//--- clock_pkg.sv
package clock_pkg;

	////////////////////////////////////////////////////////////////////////////
	// field map
	////////////////////////////////////////////////////////////////////////////

	// 4 time + 4 alarm + 3 stopwatch
	localparam int NUM_FIELDS = 11;
	localparam int FIELD_W = 8;
	localparam int FIELD_IDX_W = 4;
	// highest valid index, used for range checks on 4-bit indices
	localparam logic [FIELD_IDX_W-1:0] LAST_FIELD = 4'd10;
	localparam int RTC_ADDR_W = 8;

	// bank queues, depth is a power of two so pointers wrap on their own
	localparam int FIFO_PTR_W = 2;
	localparam int FIFO_CNT_W = 3;
	// also the credit count the controller starts with
	localparam logic [FIFO_CNT_W-1:0] FIFO_DEPTH = 3'd4;

	// mode input codes
	localparam logic [1:0] MODE_LOCK = 2'd0;
	localparam logic [1:0] MODE_TIME = 2'd1;
	localparam logic [1:0] MODE_ALARM = 2'd2;
	localparam logic [1:0] MODE_WATCH = 2'd3;

	// cursor bounds per mode, lock parks on field 0
	localparam logic [FIELD_IDX_W-1:0] GROUP_FIRST [4] = '{4'd0, 4'd0, 4'd4, 4'd8};
	localparam logic [FIELD_IDX_W-1:0] GROUP_LAST [4] = '{4'd0, 4'd3, 4'd7, 4'd10};

	// chip register address of each field
	localparam logic [RTC_ADDR_W-1:0] FIELD_RTC_ADDR [NUM_FIELDS] = '{
		8'h02, 8'h03, 8'h04, 8'h05,
		8'h09, 8'h0A, 8'h0B, 8'h0C,
		8'h10, 8'h11, 8'h12
	};

	////////////////////////////////////////////////////////////////////////////
	// bundles
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic left;
		logic right;
		logic up;
		logic down;
	} btn_t;

	// controller to bank write request
	typedef struct packed {
		logic [FIELD_IDX_W-1:0] field;
		logic [FIELD_W-1:0] value;
	} field_wr_t;

	// bank to serial master
	typedef struct packed {
		logic [RTC_ADDR_W-1:0] rtc_addr;
		logic [FIELD_W-1:0] data;
	} rtc_xfer_t;

endpackage

//--- clock_setting_top.sv
module clock_setting_top
(
	input logic CLK,
	input logic reset,
	input clock_pkg::btn_t btn_raw,
	input logic [1:0] mode,
	input logic commit,
	input logic xfer_ready,
	input logic [clock_pkg::FIELD_IDX_W-1:0] disp_field,
	output logic xfer_valid,
	output clock_pkg::rtc_xfer_t xfer,
	output logic [clock_pkg::FIELD_W-1:0] disp_data,
	output logic busy,
	output logic done
);

	clock_pkg::btn_t btn_pulse;
	clock_pkg::field_wr_t wr_req;
	logic [clock_pkg::FIELD_IDX_W-1:0] rd_field;
	logic [clock_pkg::FIELD_W-1:0] rd_data;
	logic wr_valid;
	logic credit_return;

	////////////////////////////////////////////////////////////////////////////
	// buttons -> edit controller -> register bank
	////////////////////////////////////////////////////////////////////////////

	button_sync button_sync_inst
	(
		.CLK(CLK),
		.reset(reset),
		.btn_raw(btn_raw),
		.btn_pulse(btn_pulse)
	);

	user_edit_ctrl user_edit_ctrl_inst
	(
		.CLK(CLK),
		.reset(reset),
		.mode(mode),
		.btn_pulse(btn_pulse),
		.commit(commit),
		.rd_field(rd_field),
		.rd_data(rd_data),
		.wr_valid(wr_valid),
		.wr_req(wr_req),
		.credit_return(credit_return),
		.busy(busy),
		.done(done)
	);

	rtc_reg_bank rtc_reg_bank_inst
	(
		.CLK(CLK),
		.reset(reset),
		.wr_valid(wr_valid),
		.wr_req(wr_req),
		.credit_return(credit_return),
		.rd_field(rd_field),
		.rd_data(rd_data),
		.disp_field(disp_field),
		.disp_data(disp_data),
		.xfer_valid(xfer_valid),
		.xfer(xfer),
		.xfer_ready(xfer_ready)
	);

endmodule

//--- credit_fifo.sv
module credit_fifo
#(
	parameter type payload_t = logic [7:0]
)
(
	input logic CLK,
	input logic reset,
	input logic push,
	input payload_t push_data,
	input logic pop,
	output payload_t pop_data,
	output logic empty,
	output logic full
);

	payload_t mem [clock_pkg::FIFO_DEPTH];
	logic [clock_pkg::FIFO_PTR_W-1:0] wr_ptr;
	logic [clock_pkg::FIFO_PTR_W-1:0] rd_ptr;
	logic [clock_pkg::FIFO_CNT_W-1:0] count;

	assign empty = (count == '0);
	assign full = (count == clock_pkg::FIFO_DEPTH);
	// head is visible the cycle after its push
	assign pop_data = mem[rd_ptr];

	// storage
	always_ff @(posedge CLK)
	begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	// pointers wrap at depth, count tracks occupancy
	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// producer must respect occupancy
	no_overflow: assert property (@(posedge CLK) disable iff (reset) !(push && full));
	no_underflow: assert property (@(posedge CLK) disable iff (reset) !(pop && empty));

endmodule

//--- rtc_reg_bank.sv
module rtc_reg_bank
(
	input logic CLK,
	input logic reset,
	input logic wr_valid,
	input clock_pkg::field_wr_t wr_req,
	output logic credit_return,
	input logic [clock_pkg::FIELD_IDX_W-1:0] rd_field,
	output logic [clock_pkg::FIELD_W-1:0] rd_data,
	input logic [clock_pkg::FIELD_IDX_W-1:0] disp_field,
	output logic [clock_pkg::FIELD_W-1:0] disp_data,
	output logic xfer_valid,
	output clock_pkg::rtc_xfer_t xfer,
	input logic xfer_ready
);

	clock_pkg::field_wr_t wr_head;
	clock_pkg::rtc_xfer_t xfer_in;
	logic [clock_pkg::FIELD_W-1:0] field_q [clock_pkg::NUM_FIELDS];
	logic wr_empty;
	logic wr_pop;
	logic xf_empty;
	logic xf_full;

	// write requests, sized by the controller's credits
	credit_fifo #(.payload_t(clock_pkg::field_wr_t)) wr_fifo_inst
	(
		.CLK(CLK),
		.reset(reset),
		.push(wr_valid),
		.push_data(wr_req),
		.pop(wr_pop),
		.pop_data(wr_head),
		.empty(wr_empty),
		.full()
	);

	// drain only when the outgoing side can take it
	assign wr_pop = !wr_empty && !xf_full;

	always_comb
	begin
		xfer_in.rtc_addr = (wr_head.field <= clock_pkg::LAST_FIELD) ?
			clock_pkg::FIELD_RTC_ADDR[wr_head.field] : '0;
		xfer_in.data = wr_head.value;
	end

	// plain valid/ready toward the serial master
	credit_fifo #(.payload_t(clock_pkg::rtc_xfer_t)) xfer_fifo_inst
	(
		.CLK(CLK),
		.reset(reset),
		.push(wr_pop),
		.push_data(xfer_in),
		.pop(xfer_valid && xfer_ready),
		.pop_data(xfer),
		.empty(xf_empty),
		.full(xf_full)
	);

	assign xfer_valid = !xf_empty;

	// field store plus one credit per pop
	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			for (int i = 0; i < clock_pkg::NUM_FIELDS; i++)
				field_q[i] <= '0;
			credit_return <= 1'b0;
		end
		else
		begin
			credit_return <= wr_pop;
			if (wr_pop && (wr_head.field <= clock_pkg::LAST_FIELD))
				field_q[wr_head.field] <= wr_head.value;
		end
	end

	// read ports, out of range reads zero
	assign rd_data = (rd_field <= clock_pkg::LAST_FIELD) ? field_q[rd_field] : '0;
	assign disp_data = (disp_field <= clock_pkg::LAST_FIELD) ? field_q[disp_field] : '0;

	// controller only ever scans real fields
	field_in_range: assert property (@(posedge CLK) disable iff (reset)
		wr_pop |-> (wr_head.field <= clock_pkg::LAST_FIELD));

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the clock setting testbench with Verilator

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module tb_clock_setting -o sim_clock_setting; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_clock_setting > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
exit 0

//--- tb_clock_setting.sv
module tb_clock_setting;

	localparam clock_pkg::btn_t BTN_LEFT = 4'b1000;
	localparam clock_pkg::btn_t BTN_RIGHT = 4'b0100;
	localparam clock_pkg::btn_t BTN_UP = 4'b0010;
	localparam clock_pkg::btn_t BTN_DOWN = 4'b0001;

	logic CLK;
	logic reset;
	clock_pkg::btn_t btn_raw;
	logic [1:0] mode;
	logic commit;
	logic xfer_ready;
	logic [3:0] disp_field;
	logic xfer_valid;
	clock_pkg::rtc_xfer_t xfer;
	logic [7:0] disp_data;
	logic busy;
	logic done;

	// reference model state
	logic [1:0] ref_mode;
	logic [3:0] ref_cursor;
	logic [7:0] ref_adj [11];
	logic [7:0] ref_field [11];
	logic ref_busy;
	clock_pkg::rtc_xfer_t exp_q [$];
	integer seed;
	logic hold_ready_low;
	int error_count;
	string test_name;

	clock_setting_top clock_setting_top_inst
	(
		.CLK(CLK),
		.reset(reset),
		.btn_raw(btn_raw),
		.mode(mode),
		.commit(commit),
		.xfer_ready(xfer_ready),
		.disp_field(disp_field),
		.xfer_valid(xfer_valid),
		.xfer(xfer),
		.disp_data(disp_data),
		.busy(busy),
		.done(done)
	);

	initial
	begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [3:0] group_first(input logic [1:0] m);
		case (m)
			2'd2: return 4'd4;
			2'd3: return 4'd8;
			default: return 4'd0;
		endcase
	endfunction

	function automatic logic [3:0] group_last(input logic [1:0] m);
		case (m)
			2'd1: return 4'd3;
			2'd2: return 4'd7;
			2'd3: return 4'd10;
			default: return 4'd0;
		endcase
	endfunction

	// chip map starts at 0x02 for time, 0x09 for alarm and 0x10 for the watch
	function automatic logic [7:0] rtc_addr_of(input logic [3:0] f);
		if (f < 4'd4)
			return 8'h02 + {4'h0, f};
		else if (f < 4'd8)
			return 8'h09 + ({4'h0, f} - 8'd4);
		else
			return 8'h10 + ({4'h0, f} - 8'd8);
	endfunction

	// left/right saturate at the group bounds
	function automatic logic [3:0] cursor_after(input logic [3:0] cur, input logic [1:0] m,
		input clock_pkg::btn_t b);
		if (b.left && (cur > group_first(m)))
			return cur - 4'd1;
		if (b.right && (cur < group_last(m)))
			return cur + 4'd1;
		return cur;
	endfunction

	function automatic logic [7:0] adj_after(input logic [7:0] a, input clock_pkg::btn_t b);
		if (b.up)
			return a + 8'd1;
		if (b.down)
			return a - 8'd1;
		return a;
	endfunction

	// stored plus adjustment modulo 256
	function automatic logic [7:0] commit_value(input logic [7:0] stored, input logic [7:0] a);
		return stored + a;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// error reporting
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		error_count++;
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string what, input int expected, input int actual);
		$display("FAILED %s: expected %0d, actual %0d", what, expected, actual);
		abort_run();
	endtask

	task automatic report_problem(input string why);
		$display("ERROR %s", why);
		abort_run();
	endtask

	task automatic check_equal(input string what, input int expected, input int actual);
		assert (expected == actual)
		else
			report_mismatch(what, expected, actual);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers that drive 1 unit after the edge
	////////////////////////////////////////////////////////////////////////////

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge CLK);
		#1;
	endtask

	// held 5 cycles and released 5 so the pulse lands well inside
	task automatic press(input clock_pkg::btn_t b, input int n);
		repeat (n)
		begin
			if (!ref_busy && (ref_mode != 2'd0))
			begin
				ref_adj[ref_cursor] = adj_after(ref_adj[ref_cursor], b);
				ref_cursor = cursor_after(ref_cursor, ref_mode, b);
			end
			btn_raw = b;
			wait_cycles(5);
			btn_raw = '0;
			wait_cycles(5);
		end
	endtask

	task automatic set_mode(input logic [1:0] m);
		if (m != ref_mode)
			ref_cursor = group_first(m);
		ref_mode = m;
		mode = m;
		wait_cycles(2);
	endtask

	// expected transfers go in field order
	task automatic start_commit();
		clock_pkg::rtc_xfer_t t;
		for (int i = 0; i < 11; i++)
		begin
			if (ref_adj[i] != 8'd0)
			begin
				ref_field[i] = commit_value(ref_field[i], ref_adj[i]);
				ref_adj[i] = 8'd0;
				t.rtc_addr = rtc_addr_of(i[3:0]);
				t.data = ref_field[i];
				exp_q.push_back(t);
			end
		end
		commit = 1'b1;
		wait_cycles(1);
		commit = 1'b0;
	endtask

	task automatic wait_done(input int limit);
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && (n < limit))
		begin
			@(negedge CLK);
			seen = (done === 1'b1);
			n++;
		end
		assert (seen)
		else
			report_problem($sformatf("%s: timeout waiting for done", test_name));
		wait_cycles(1);
	endtask

	// done can lead the last transfer when the outgoing queue is backed up
	task automatic wait_drained(input int limit);
		int n;
		n = 0;
		while (((exp_q.size() != 0) || (xfer_valid !== 1'b0)) && (n < limit))
		begin
			wait_cycles(1);
			n++;
		end
		assert ((exp_q.size() == 0) && (xfer_valid === 1'b0))
		else
			report_problem($sformatf("%s: timeout, %0d transfers missing", test_name,
				exp_q.size()));
	endtask

	task automatic check_display(input logic [3:0] f);
		disp_field = f;
		@(negedge CLK);
		check_equal($sformatf("%s disp field %0d", test_name, f), ref_field[f], disp_data);
		wait_cycles(1);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// transfer checker and ready driver
	////////////////////////////////////////////////////////////////////////////

	// handshake seen at negedge completes on the next edge
	initial
	begin
		clock_pkg::rtc_xfer_t exp;
		forever
		begin
			@(negedge CLK);
			if (!reset && xfer_valid && xfer_ready)
			begin
				assert (exp_q.size() != 0)
				else
					report_problem($sformatf("%s: unexpected transfer addr %0h data %0d",
						test_name, xfer.rtc_addr, xfer.data));
				exp = exp_q.pop_front();
				check_equal({test_name, " xfer addr"}, exp.rtc_addr, xfer.rtc_addr);
				check_equal({test_name, " xfer data"}, exp.data, xfer.data);
			end
		end
	end

	initial
	begin
		logic [31:0] r;
		forever
		begin
			@(posedge CLK);
			#1;
			r = $random(seed);
			xfer_ready = hold_ready_low ? 1'b0 : r[0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		reset = 1'b1;
		btn_raw = '0;
		mode = 2'd0;
		commit = 1'b0;
		xfer_ready = 1'b0;
		disp_field = 4'd0;
		hold_ready_low = 1'b0;
		seed = 32'h6127;
		error_count = 0;
		test_name = "reset";
		ref_mode = 2'd0;
		ref_cursor = 4'd0;
		ref_busy = 1'b0;
		for (int i = 0; i < 11; i++)
		begin
			ref_adj[i] = 8'd0;
			ref_field[i] = 8'd0;
		end
		repeat (4) @(posedge CLK);
		#1;
		reset = 1'b0;
		check_equal("reset busy", 0, busy);
		check_equal("reset done", 0, done);

		// field 2 gets 3
		test_name = "time edit";
		set_mode(2'd1);
		press(BTN_RIGHT, 2);
		press(BTN_UP, 3);
		start_commit();
		wait_done(500);
		wait_drained(200);
		check_display(4'd2);

		// left stays on 4 and right stops at 10
		test_name = "saturate";
		set_mode(2'd2);
		press(BTN_LEFT, 2);
		press(BTN_DOWN, 1);
		set_mode(2'd3);
		press(BTN_RIGHT, 5);
		press(BTN_UP, 1);
		start_commit();
		wait_done(500);
		wait_drained(200);
		check_display(4'd4);
		check_display(4'd10);

		test_name = "lock";
		set_mode(2'd0);
		press(BTN_UP, 2);
		press(BTN_RIGHT, 1);
		start_commit();
		wait_done(500);
		wait_drained(200);
		check_display(4'd0);

		test_name = "accumulate";
		set_mode(2'd1);
		press(BTN_RIGHT, 2);
		press(BTN_UP, 5);
		start_commit();
		wait_done(500);
		wait_drained(200);
		check_display(4'd2);

		// every field gets a press with even fields up and odd fields down
		test_name = "backpressure";
		// lock first so the time group snaps back to field 0
		set_mode(2'd0);
		for (int m = 1; m < 4; m++)
		begin
			set_mode(m[1:0]);
			for (int f = group_first(m[1:0]); f <= group_last(m[1:0]); f++)
			begin
				press((f % 2 == 0) ? BTN_UP : BTN_DOWN, 1);
				if (f < group_last(m[1:0]))
					press(BTN_RIGHT, 1);
			end
		end
		hold_ready_low = 1'b1;
		start_commit();
		// press while the scan is stalled
		ref_busy = 1'b1;
		press(BTN_UP, 1);
		check_equal("busy under backpressure", 1, busy);
		wait_cycles(29);
		hold_ready_low = 1'b0;
		ref_busy = 1'b0;
		wait_done(1000);
		wait_drained(500);
		for (int f = 0; f < 11; f++)
			check_display(f[3:0]);

		// the ignored press left nothing pending
		test_name = "busy ignore";
		start_commit();
		wait_done(500);
		wait_drained(200);
		check_display(4'd10);

		if (error_count == 0)
		begin
			$display("Done: no errors");
			$finish;
		end
		else
			abort_run();
	end

endmodule

//--- user_edit_ctrl.sv
module user_edit_ctrl
(
	input logic CLK,
	input logic reset,
	input logic [1:0] mode,
	input clock_pkg::btn_t btn_pulse,
	input logic commit,
	output logic [clock_pkg::FIELD_IDX_W-1:0] rd_field,
	input logic [clock_pkg::FIELD_W-1:0] rd_data,
	output logic wr_valid,
	output clock_pkg::field_wr_t wr_req,
	input logic credit_return,
	output logic busy,
	output logic done
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SCAN,
		ST_DRAIN
	} state_t;

	state_t state;
	logic [1:0] mode_q;
	logic [clock_pkg::FIELD_IDX_W-1:0] cursor;
	logic [clock_pkg::FIELD_IDX_W-1:0] scan_idx;
	logic [clock_pkg::FIELD_IDX_W-1:0] grp_first;
	logic [clock_pkg::FIELD_IDX_W-1:0] grp_last;
	logic [clock_pkg::FIELD_W-1:0] adj [clock_pkg::NUM_FIELDS];
	logic [clock_pkg::FIFO_CNT_W-1:0] credits;
	logic [clock_pkg::FIFO_CNT_W-1:0] credits_next;
	logic edit_en;
	logic scan_hit;

	// bounds of the group picked by mode
	assign grp_first = clock_pkg::GROUP_FIRST[mode];
	assign grp_last = clock_pkg::GROUP_LAST[mode];

	// buttons only count while idle and unlocked
	assign edit_en = (state == ST_IDLE) && (mode != clock_pkg::MODE_LOCK);
	assign busy = (state != ST_IDLE);

	////////////////////////////////////////////////////////////////////////////
	// cursor and pending adjustments
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			cursor <= '0;
			mode_q <= clock_pkg::MODE_LOCK;
		end
		else
		begin
			mode_q <= mode;
			// new mode wins over a move on the same edge
			if (mode != mode_q)
				cursor <= grp_first;
			else if (edit_en && btn_pulse.left && (cursor > grp_first))
				cursor <= cursor - 1'b1;
			else if (edit_en && btn_pulse.right && (cursor < grp_last))
				cursor <= cursor + 1'b1;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			for (int i = 0; i < clock_pkg::NUM_FIELDS; i++)
				adj[i] <= '0;
		end
		// issued write consumes its adjustment
		else if (wr_valid)
			adj[scan_idx] <= '0;
		// wraps at 256
		else if (edit_en && btn_pulse.up)
			adj[cursor] <= adj[cursor] + 1'b1;
		else if (edit_en && btn_pulse.down)
			adj[cursor] <= adj[cursor] - 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// commit sequencer
	////////////////////////////////////////////////////////////////////////////

	// bank read follows the scan
	assign rd_field = scan_idx;

	// current field has something pending
	assign scan_hit = (state == ST_SCAN) && (adj[scan_idx] != '0);
	// requests only while credits remain
	assign wr_valid = scan_hit && (credits != '0);

	always_comb
	begin
		wr_req.field = scan_idx;
		wr_req.value = rd_data + adj[scan_idx];
	end

	// spend on each request and gain on each return
	always_comb
	begin
		credits_next = credits;
		if (wr_valid)
			credits_next = credits_next - 1'b1;
		if (credit_return)
			credits_next = credits_next + 1'b1;
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
			scan_idx <= '0;
			credits <= clock_pkg::FIFO_DEPTH;
			done <= 1'b0;
		end
		else
		begin
			credits <= credits_next;
			done <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					// accepted in any mode
					if (commit)
					begin
						state <= ST_SCAN;
						scan_idx <= '0;
					end
				end
				ST_SCAN:
				begin
					// move on unless stalled on a hit without credit
					if (!scan_hit || wr_valid)
					begin
						if (scan_idx == clock_pkg::LAST_FIELD)
							state <= ST_DRAIN;
						else
							scan_idx <= scan_idx + 1'b1;
					end
				end
				ST_DRAIN:
				begin
					// all requests popped by the bank
					if (credits == clock_pkg::FIFO_DEPTH)
					begin
						done <= 1'b1;
						state <= ST_IDLE;
					end
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// bank returns no more credits than were spent
	credit_bound: assert property (@(posedge CLK) disable iff (reset)
		credits <= clock_pkg::FIFO_DEPTH);
	// a pending field holds the scan while no credits remain
	stall_without_credit: assert property (@(posedge CLK) disable iff (reset)
		(scan_hit && (credits == '0)) |=> ((state == ST_SCAN) && $stable(scan_idx)));

endmodule

//--- verilog.f
clock_pkg.sv
button_sync.sv
credit_fifo.sv
user_edit_ctrl.sv
rtc_reg_bank.sv
clock_setting_top.sv
tb_clock_setting.sv
